//--- vlog.f
source/ahb_pkg.sv
source/ahb_master.sv
source/ahb_arbiter.sv
source/ahb_decoder.sv
source/ahb_sram.sv
source/ahb_apb_bridge.sv
source/apb_regs.sv
source/ahb_subsystem.sv
verification/tb_ahb_subsystem.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ahb_subsystem
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= STATUS: PASS

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- verification/tb_ahb_subsystem.sv
module tb_ahb_subsystem import ahb_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ns;

    localparam int clk_period      = 100;
    localparam int reset_cycles    = 8;
    localparam int done_limit      = 40;   // Worst case cycles for one transfer
    localparam int test_transfers  = 120;
    localparam int watchdog_cycles = 2 * reset_cycles + test_transfers * done_limit;

    logic  clk, reset;
    logic  cpu_start, cpu_write, cpu_done, cpu_error, cpu_busy;
    addr_t cpu_addr;
    data_t cpu_wdata, cpu_rdata;
    logic  dma_start, dma_write, dma_done, dma_error, dma_busy;
    addr_t dma_addr;
    data_t dma_wdata, dma_rdata;

    data_t       sram_model [256];
    logic        sram_valid [256];
    data_t       reg_model [8];
    logic [31:0] lfsr;
    int          error_count, check_count;

    ahb_subsystem u_ahb_subsystem (
        .clk(clk), .reset(reset),
        .cpu_start(cpu_start), .cpu_addr(cpu_addr), .cpu_write(cpu_write),
        .cpu_wdata(cpu_wdata), .cpu_done(cpu_done), .cpu_rdata(cpu_rdata),
        .cpu_error(cpu_error), .cpu_busy(cpu_busy),
        .dma_start(dma_start), .dma_addr(dma_addr), .dma_write(dma_write),
        .dma_wdata(dma_wdata), .dma_done(dma_done), .dma_rdata(dma_rdata),
        .dma_error(dma_error), .dma_busy(dma_busy)
    );

    always #(clk_period / 2) clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    function automatic string port_sig(input logic use_dma, input string sig);
        return $sformatf("%s_%s", use_dma ? "dma" : "cpu", sig);
    endfunction

    task automatic check_data(input string name, input data_t got, input data_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset     <= 1'b1;
        cpu_start <= 1'b0;
        dma_start <= 1'b0;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < 8; i++) begin
            reg_model[i] = '0;
        end
    endtask

    task automatic start_pulse(input logic use_dma, input addr_t a, input logic wr,
                               input data_t wd);
        @(posedge clk);
        if (use_dma) begin
            dma_start <= 1'b1;
            dma_addr  <= a;
            dma_write <= wr;
            dma_wdata <= wd;
        end else begin
            cpu_start <= 1'b1;
            cpu_addr  <= a;
            cpu_write <= wr;
            cpu_wdata <= wd;
        end
        @(posedge clk);
        cpu_start <= 1'b0;
        dma_start <= 1'b0;
    endtask

    // One transfer on one port checked against the expected response
    task automatic access(input logic use_dma, input addr_t a, input logic wr, input data_t wd,
                          input logic exp_err, input logic check_rd, input data_t exp_rd);
        int   cycles;
        logic seen;
        start_pulse(use_dma, a, wr, wd);
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < done_limit) begin
            @(negedge clk);
            seen = use_dma ? dma_done : cpu_done;
            cycles++;
        end
        if (!seen) begin
            error_count++;
            $display("%s port gave no done within %0d cycles", use_dma ? "DMA" : "CPU", done_limit);
        end
        check_flag(port_sig(use_dma, "error"), use_dma ? dma_error : cpu_error, exp_err);
        if (check_rd) check_data(port_sig(use_dma, "rdata"), use_dma ? dma_rdata : cpu_rdata, exp_rd);
        if (seen) begin
            // Busy covers the done cycle and drops right after it
            check_flag(port_sig(use_dma, "busy"), use_dma ? dma_busy : cpu_busy, 1'b1);
            @(negedge clk);
            check_flag(port_sig(use_dma, "busy"), use_dma ? dma_busy : cpu_busy, 1'b0);
        end
    endtask

    task automatic sram_access(input logic use_dma, input addr_t a, input logic wr, input data_t d);
        if (wr) begin
            sram_model[a[9:2]] = d;   // Index ignores the 1 KB alias bits
            sram_valid[a[9:2]] = 1'b1;
            access(use_dma, a, 1'b1, d, 1'b0, 1'b0, '0);
        end else begin
            access(use_dma, a, 1'b0, '0, 1'b0, 1'b1, sram_model[a[9:2]]);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) $display("%s: ok", name);
        else $display("%s: %0d errors", name, error_count - errors_before);
    endtask

    task automatic test_sram_both_ports();
        int errors_before;
        errors_before = error_count;
        @(negedge clk);
        check_flag("cpu_busy", cpu_busy, 1'b0);
        check_flag("dma_busy", dma_busy, 1'b0);
        sram_access(1'b0, sram_base + 32'h10, 1'b1, 32'h1234_5678);
        sram_access(1'b0, sram_base + 32'h10, 1'b0, '0);
        sram_access(1'b1, sram_base + 32'h20, 1'b1, 32'hcafe_0001);
        sram_access(1'b1, sram_base + 32'h20, 1'b0, '0);
        report_test("test 1 sram from both ports", errors_before);
    endtask

    task automatic test_apb_registers();
        logic [31:0] value;
        int          errors_before;
        errors_before = error_count;
        for (int i = 0; i < 8; i++) begin
            random_bits(32, value);
            reg_model[i] = value;
            access(1'b0, apb_base + addr_t'(i * 4), 1'b1, value, 1'b0, 1'b0, '0);
        end
        for (int i = 0; i < 8; i++) begin
            access(1'b1, apb_base + addr_t'(i * 4), 1'b0, '0, 1'b0, 1'b1, reg_model[i]);
        end
        // Offsets past the register block
        access(1'b0, apb_base + apb_reg_span, 1'b1, 32'hdead_beef, 1'b1, 1'b0, '0);
        access(1'b1, apb_base + apb_reg_span + 32'h40, 1'b0, '0, 1'b1, 1'b0, '0);
        for (int i = 0; i < 8; i++) begin
            access(1'b0, apb_base + addr_t'(i * 4), 1'b0, '0, 1'b0, 1'b1, reg_model[i]);
        end
        report_test("test 2 apb registers", errors_before);
    endtask

    task automatic test_unmapped();
        int errors_before;
        errors_before = error_count;
        access(1'b0, 32'h0000_1000, 1'b1, 32'h0bad_0bad, 1'b1, 1'b0, '0);
        access(1'b1, 32'h0000_1000, 1'b0, '0, 1'b1, 1'b0, '0);
        access(1'b1, 32'h0100_0000, 1'b1, 32'h0bad_0bad, 1'b1, 1'b0, '0);
        access(1'b0, 32'h0100_0000, 1'b0, '0, 1'b1, 1'b0, '0);
        report_test("test 3 unmapped addresses", errors_before);
    endtask

    // Both ports start on one edge and report the cycle of each done
    task automatic paired_start(input addr_t ca, input logic cw, input data_t cd, input addr_t da,
                                input logic dw, input data_t dd, output int cpu_at, output int dma_at);
        int cycles;
        @(posedge clk);
        cpu_start <= 1'b1;
        cpu_addr  <= ca;
        cpu_write <= cw;
        cpu_wdata <= cd;
        dma_start <= 1'b1;
        dma_addr  <= da;
        dma_write <= dw;
        dma_wdata <= dd;
        @(posedge clk);
        cpu_start <= 1'b0;
        dma_start <= 1'b0;
        cpu_at = 0;
        dma_at = 0;
        cycles = 0;
        while ((cpu_at == 0 || dma_at == 0) && cycles < 2 * done_limit) begin
            @(negedge clk);
            cycles++;
            if (cpu_done) begin
                cpu_at = cycles;
                check_flag("cpu_error", cpu_error, 1'b0);
                if (!cw) check_data("cpu_rdata", cpu_rdata, sram_model[ca[9:2]]);
            end
            if (dma_done) begin
                dma_at = cycles;
                check_flag("dma_error", dma_error, 1'b0);
                if (!dw) check_data("dma_rdata", dma_rdata, sram_model[da[9:2]]);
            end
        end
        if (cpu_at == 0 || dma_at == 0) begin
            error_count++;
            $display("Paired start did not finish on both ports within %0d cycles", 2 * done_limit);
        end
    endtask

    task automatic test_arbitration();
        int cpu_at, dma_at, dones, errors_before;
        errors_before = error_count;
        apply_reset();
        sram_model[8'h40] = 32'h1111_aaaa;
        sram_model[8'h41] = 32'h2222_bbbb;
        paired_start(sram_base + 32'h100, 1'b1, 32'h1111_aaaa,
                     sram_base + 32'h104, 1'b1, 32'h2222_bbbb, cpu_at, dma_at);
        if (!(cpu_at < dma_at)) begin
            error_count++;
            $display("DMA done at cycle %0d came before CPU done at cycle %0d", dma_at, cpu_at);
        end
        paired_start(sram_base + 32'h104, 1'b0, '0, sram_base + 32'h100, 1'b0, '0, cpu_at, dma_at);
        // Second start lands while the first transfer is still busy
        start_pulse(1'b0, sram_base + 32'h200, 1'b1, 32'h3333_cccc);
        @(posedge clk);
        start_pulse(1'b0, sram_base + 32'h010, 1'b1, 32'h4444_dddd);
        dones = 0;
        repeat (done_limit) begin
            @(negedge clk);
            if (cpu_done) dones++;
        end
        if (dones != 1) begin
            error_count++;
            $display("CPU port gave %0d done pulses for one accepted start", dones);
        end
        sram_model[8'h80] = 32'h3333_cccc;
        sram_access(1'b0, sram_base + 32'h200, 1'b0, '0);
        sram_access(1'b1, sram_base + 32'h010, 1'b0, '0);   // Unchanged since test 1
        report_test("test 4 arbitration and busy", errors_before);
    endtask

    task automatic test_random_sram();
        logic [31:0] use_dma, dir, index, block, value;
        addr_t       a;
        int          errors_before;
        errors_before = error_count;
        repeat (40) begin
            random_bits(1, use_dma);
            random_bits(1, dir);
            random_bits(8, index);
            random_bits(10, block);
            random_bits(32, value);
            a = sram_base + {12'h000, block[9:0], index[7:0], 2'b00};
            // Reads only where the model holds a value
            if (dir[0] && sram_valid[index[7:0]]) sram_access(use_dma[0], a, 1'b0, '0);
            else sram_access(use_dma[0], a, 1'b1, value);
        end
        report_test("test 5 random sram", errors_before);
    endtask

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Watchdog expired after %0d cycles", watchdog_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        cpu_start = 1'b0;
        cpu_addr = '0;
        cpu_write = 1'b0;
        cpu_wdata = '0;
        dma_start = 1'b0;
        dma_addr = '0;
        dma_write = 1'b0;
        dma_wdata = '0;
        lfsr = 32'h548f;
        error_count = 0;
        check_count = 0;
        for (int i = 0; i < 256; i++) begin
            sram_valid[i] = 1'b0;
        end
        apply_reset();
        test_sram_both_ports();
        test_apb_registers();
        test_unmapped();
        test_arbitration();
        test_random_sram();
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- source/ahb_subsystem.sv
module ahb_subsystem import ahb_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  cpu_start,
    input  addr_t cpu_addr,
    input  logic  cpu_write,
    input  data_t cpu_wdata,
    output logic  cpu_done,
    output data_t cpu_rdata,
    output logic  cpu_error,
    output logic  cpu_busy,
    input  logic  dma_start,
    input  addr_t dma_addr,
    input  logic  dma_write,
    input  data_t dma_wdata,
    output logic  dma_done,
    output data_t dma_rdata,
    output logic  dma_error,
    output logic  dma_busy
);

    // Master side
    logic    cpu_req, dma_req;
    logic    cpu_grant, dma_grant;
    addr_t   cpu_haddr, dma_haddr;
    htrans_t cpu_htrans, dma_htrans;
    logic    cpu_hwrite, dma_hwrite;
    data_t   cpu_hwdata, dma_hwdata;

    // Shared bus
    addr_t   haddr;
    htrans_t htrans;
    logic    hwrite;
    data_t   hwdata;
    logic    hready;
    data_t   hrdata;
    logic    hresp;
    logic    hsel_sram, hsel_apb;

    data_t   sram_hrdata, apb_hrdata;
    logic    sram_hreadyout, apb_hreadyout;
    logic    sram_hresp, apb_hresp;

    // APB side
    addr_t   paddr;
    logic    psel, penable, pwrite;
    data_t   pwdata, prdata;
    logic    pready, pslverr;

    // Granted master drives the bus, idle when nobody owns it
    assign haddr  = dma_grant ? dma_haddr : cpu_haddr;
    assign htrans = cpu_grant ? cpu_htrans : (dma_grant ? dma_htrans : trans_idle);
    assign hwrite = dma_grant ? dma_hwrite : cpu_hwrite;
    assign hwdata = dma_grant ? dma_hwdata : cpu_hwdata;

    ahb_master u_cpu_master (
        .clk(clk), .reset(reset),
        .start(cpu_start), .addr(cpu_addr), .write(cpu_write), .wdata(cpu_wdata),
        .done(cpu_done), .rdata(cpu_rdata), .error(cpu_error), .busy(cpu_busy),
        .grant(cpu_grant), .req(cpu_req),
        .haddr(cpu_haddr), .htrans(cpu_htrans), .hwrite(cpu_hwrite), .hwdata(cpu_hwdata),
        .hready(hready), .hrdata(hrdata), .hresp(hresp)
    );

    ahb_master u_dma_master (
        .clk(clk), .reset(reset),
        .start(dma_start), .addr(dma_addr), .write(dma_write), .wdata(dma_wdata),
        .done(dma_done), .rdata(dma_rdata), .error(dma_error), .busy(dma_busy),
        .grant(dma_grant), .req(dma_req),
        .haddr(dma_haddr), .htrans(dma_htrans), .hwrite(dma_hwrite), .hwdata(dma_hwdata),
        .hready(hready), .hrdata(hrdata), .hresp(hresp)
    );

    ahb_arbiter u_ahb_arbiter (
        .clk(clk), .reset(reset),
        .cpu_req(cpu_req), .dma_req(dma_req),
        .cpu_grant(cpu_grant), .dma_grant(dma_grant)
    );

    ahb_decoder u_ahb_decoder (
        .clk(clk), .reset(reset),
        .haddr(haddr), .htrans(htrans), .hready(hready),
        .hsel_sram(hsel_sram), .hsel_apb(hsel_apb),
        .sram_hrdata(sram_hrdata), .apb_hrdata(apb_hrdata),
        .sram_hreadyout(sram_hreadyout), .apb_hreadyout(apb_hreadyout),
        .sram_hresp(sram_hresp), .apb_hresp(apb_hresp),
        .hrdata(hrdata), .hresp(hresp)
    );

    ahb_sram u_ahb_sram (
        .clk(clk), .reset(reset),
        .hsel(hsel_sram), .haddr(haddr), .htrans(htrans), .hwrite(hwrite),
        .hwdata(hwdata), .hready(hready),
        .hrdata(sram_hrdata), .hreadyout(sram_hreadyout), .hresp(sram_hresp)
    );

    ahb_apb_bridge u_ahb_apb_bridge (
        .clk(clk), .reset(reset),
        .hsel(hsel_apb), .haddr(haddr), .htrans(htrans), .hwrite(hwrite),
        .hwdata(hwdata), .hready(hready),
        .hrdata(apb_hrdata), .hreadyout(apb_hreadyout), .hresp(apb_hresp),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    apb_regs u_apb_regs (
        .clk(clk), .reset(reset),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

endmodule

//--- source/apb_regs.sv
module apb_regs import ahb_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  addr_t paddr,
    input  logic  psel,
    input  logic  penable,
    input  logic  pwrite,
    input  data_t pwdata,
    output data_t prdata,
    output logic  pready,
    output logic  pslverr
);

    data_t      regs [8];
    reg_index_t index;
    logic       bad_offset;
    logic       waited;    // First access cycle has passed

    assign index      = paddr[4:2];
    assign bad_offset = (paddr >= apb_reg_span);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            waited <= 1'b0;
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else begin
            waited <= psel && penable && !pready;
            if (pready && pwrite && !bad_offset) begin
                regs[index] <= pwdata;
            end
        end
    end

    assign pready  = psel && penable && waited;
    assign pslverr = pready && bad_offset;
    assign prdata  = (psel && !pwrite && !bad_offset) ? regs[index] : '0;

endmodule

//--- source/ahb_apb_bridge.sv
module ahb_apb_bridge import ahb_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    hsel,
    input  addr_t   haddr,
    input  htrans_t htrans,
    input  logic    hwrite,
    input  data_t   hwdata,
    input  logic    hready,
    output data_t   hrdata,
    output logic    hreadyout,
    output logic    hresp,
    output addr_t   paddr,
    output logic    psel,
    output logic    penable,
    output logic    pwrite,
    output data_t   pwdata,
    input  data_t   prdata,
    input  logic    pready,
    input  logic    pslverr
);

    bridge_state_t state;
    data_t         wdata_q;
    logic          accept;
    logic          complete;

    assign accept   = hsel && (htrans == trans_nonseq) && hready;
    assign complete = (state == bridge_access) && pready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= bridge_idle;
            hreadyout <= 1'b1;
            hresp     <= 1'b0;
        end else begin
            case (state)
                bridge_idle: begin
                    hresp <= 1'b0;  // Response lasts one cycle
                    if (accept) begin
                        state     <= bridge_setup;
                        hreadyout <= 1'b0;
                    end
                end
                bridge_setup: state <= bridge_access;
                bridge_access: begin
                    if (pready) begin
                        state     <= bridge_idle;
                        hreadyout <= 1'b1;
                        hresp     <= pslverr;
                    end
                end
                default: state <= bridge_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept && state == bridge_idle) begin
            paddr  <= haddr - apb_base;  // Offset within the APB region
            pwrite <= hwrite;
        end
        // AHB write data arrives in the first data phase cycle
        if (state == bridge_setup) wdata_q <= hwdata;
        if (complete) hrdata <= prdata;
    end

    assign psel    = (state != bridge_idle);
    assign penable = (state == bridge_access);
    assign pwdata  = (state == bridge_setup) ? hwdata : wdata_q;

endmodule

//--- source/ahb_sram.sv
module ahb_sram import ahb_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    hsel,
    input  addr_t   haddr,
    input  htrans_t htrans,
    input  logic    hwrite,
    input  data_t   hwdata,
    input  logic    hready,
    output data_t   hrdata,
    output logic    hreadyout,
    output logic    hresp
);

    data_t       mem [256];
    sram_index_t index_q;
    logic        write_pending;
    logic        accept;

    assign accept = hsel && (htrans == trans_nonseq) && hready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            write_pending <= 1'b0;
        end else if (hready) begin
            write_pending <= accept && hwrite;
        end
    end

    // Address phase capture
    always_ff @(posedge clk) begin
        if (accept) index_q <= haddr[9:2];  // Aliases every 1 KB
    end

    // Write lands at the end of the data phase
    always_ff @(posedge clk) begin
        if (write_pending) mem[index_q] <= hwdata;
    end

    assign hrdata    = mem[index_q];
    assign hreadyout = 1'b1;   // Zero wait states
    assign hresp     = 1'b0;

endmodule

//--- source/ahb_decoder.sv
module ahb_decoder import ahb_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  addr_t   haddr,
    input  htrans_t htrans,
    output logic    hready,
    output logic    hsel_sram,
    output logic    hsel_apb,
    input  data_t   sram_hrdata,
    input  data_t   apb_hrdata,
    input  logic    sram_hreadyout,
    input  logic    apb_hreadyout,
    input  logic    sram_hresp,
    input  logic    apb_hresp,
    output data_t   hrdata,
    output logic    hresp
);

    logic transfer;
    logic unmapped;
    logic data_sram;     // Data phase owners
    logic data_apb;
    logic data_default;

    assign transfer  = (htrans == trans_nonseq);
    assign hsel_sram = (haddr >= sram_base) && (haddr < sram_limit);
    assign hsel_apb  = (haddr >= apb_base) && (haddr < apb_limit);
    assign unmapped  = !hsel_sram && !hsel_apb;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            data_sram    <= 1'b0;
            data_apb     <= 1'b0;
            data_default <= 1'b0;
        end else if (hready) begin
            data_sram    <= hsel_sram && transfer;
            data_apb     <= hsel_apb && transfer;
            data_default <= unmapped && transfer;  // Default slave takes it
        end
    end

    // Response mux
    always_comb begin
        hready = 1'b1;
        hrdata = '0;
        hresp  = 1'b0;
        if (data_sram) begin
            hready = sram_hreadyout;
            hrdata = sram_hrdata;
            hresp  = sram_hresp;
        end else if (data_apb) begin
            hready = apb_hreadyout;
            hrdata = apb_hrdata;
            hresp  = apb_hresp;
        end else if (data_default) begin
            hresp = 1'b1;  // One-cycle error
        end
    end

endmodule

//--- source/ahb_arbiter.sv
module ahb_arbiter import ahb_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic cpu_req,
    input  logic dma_req,
    output logic cpu_grant,
    output logic dma_grant
);

    arb_state_t turn;
    logic       owner_holds;

    // Grant stays put while its owner still requests
    assign owner_holds = (cpu_grant && cpu_req) || (dma_grant && dma_req);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            turn      <= cpu_priority;
            cpu_grant <= 1'b0;
            dma_grant <= 1'b0;
        end else if (!owner_holds) begin
            cpu_grant <= 1'b0;
            dma_grant <= 1'b0;
            if (cpu_req && (turn == cpu_priority || !dma_req)) begin
                cpu_grant <= 1'b1;
                turn      <= dma_priority;  // DMA goes first next time
            end else if (dma_req) begin
                dma_grant <= 1'b1;
                turn      <= cpu_priority;
            end
        end
    end

endmodule

//--- source/ahb_master.sv
module ahb_master import ahb_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    start,
    input  addr_t   addr,
    input  logic    write,
    input  data_t   wdata,
    output logic    done,
    output data_t   rdata,
    output logic    error,
    output logic    busy,
    input  logic    grant,
    output logic    req,
    output addr_t   haddr,
    output htrans_t htrans,
    output logic    hwrite,
    output data_t   hwdata,
    input  logic    hready,
    input  data_t   hrdata,
    input  logic    hresp
);

    master_state_t state;
    addr_t         addr_q;
    logic          write_q;
    data_t         wdata_q;
    logic          take_cmd;
    logic          finish;

    assign take_cmd = (state == master_idle) && start && !busy;
    assign finish   = (state == master_data) && hready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= master_idle;
            done  <= 1'b0;
            error <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                master_idle:    if (take_cmd) state <= master_request;
                master_request: if (grant && hready) state <= master_address;
                master_address: if (hready) state <= master_data;  // Address accepted
                master_data: begin
                    if (hready) begin
                        state <= master_idle;
                        done  <= 1'b1;
                        error <= hresp;
                    end
                end
                default: state <= master_idle;
            endcase
        end
    end

    // Command and read data registers
    always_ff @(posedge clk) begin
        if (take_cmd) begin
            addr_q  <= addr;
            write_q <= write;
            wdata_q <= wdata;
        end
        if (finish) rdata <= hrdata;
    end

    assign busy   = (state != master_idle) || done;  // Covers the done cycle too
    assign req    = (state != master_idle);
    assign haddr  = addr_q;
    assign htrans = (state == master_address) ? trans_nonseq : trans_idle;
    assign hwrite = write_q;
    assign hwdata = wdata_q;   // Held through the whole data phase

endmodule

//--- source/ahb_pkg.sv
package ahb_pkg;

    // Bus word types
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [1:0]  htrans_t;

    typedef logic [7:0] sram_index_t;   // Address bits 9:2
    typedef logic [2:0] reg_index_t;    // Address bits 4:2

    localparam htrans_t trans_idle   = 2'b00;
    localparam htrans_t trans_nonseq = 2'b10;

    // Address map
    localparam addr_t sram_base    = 32'h0010_0000;
    localparam addr_t sram_limit   = 32'h0020_0000;
    localparam addr_t apb_base     = 32'h0020_0000;
    localparam addr_t apb_limit    = 32'h0100_0000;
    localparam addr_t apb_reg_span = 32'h0000_0020;

    typedef enum logic [1:0] {
        master_idle,
        master_request,
        master_address,
        master_data
    } master_state_t;

    typedef enum logic {
        cpu_priority,
        dma_priority
    } arb_state_t;

    typedef enum logic [1:0] {
        bridge_idle,
        bridge_setup,
        bridge_access
    } bridge_state_t;

endpackage
